/* hog_norm.f */
logic/hog_fixed_pkg.sv
logic/hog_cell_pkg.sv
logic/block_energy_sum.sv
logic/inv_sqrt_approx.sv
logic/norm_bank.sv
logic/truncate_sum.sv
logic/orientation_pca.sv
logic/texture_accumulator.sv
logic/hog_norm_pca.sv
+incdir+verification
verification/hog_norm_tb.sv

/* logic/block_energy_sum.sv */
// block energy sequencer
`timescale 1ns/1ps

module block_energy_sum (
	input logic aclk,
	input logic rst_n,
	input logic window_valid,
	input hog_fixed_pkg::energy_t window_energy [hog_cell_pkg::WIN_CELLS],
	output logic blk_valid,
	output hog_fixed_pkg::energy_t blk_energy
);

	typedef enum logic [2:0] {S_IDLE, S_BLK0, S_BLK1, S_BLK2, S_BLK3} state_t;

	state_t state_q, state_n;
	hog_fixed_pkg::energy_t win_q [hog_cell_pkg::WIN_CELLS];
	logic [1:0] blk_idx;
	hog_fixed_pkg::energy_t blk_sum;

	always_comb begin
		case (state_q)
			S_IDLE: state_n = window_valid ? S_BLK0 : S_IDLE;
			S_BLK0: state_n = S_BLK1;
			S_BLK1: state_n = S_BLK2;
			S_BLK2: state_n = S_BLK3;
			default: state_n = S_IDLE;
		endcase
	end

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			state_q <= S_IDLE;
		end else begin
			state_q <= state_n;
		end
	end

	// window held for the four block cycles
	always_ff @(posedge aclk) begin
		if (state_q == S_IDLE && window_valid) begin
			win_q <= window_energy;
		end
	end

	// S_BLK0..S_BLK3 are 1..4, low bits minus one give 0..3
	assign blk_idx = state_q[1:0] - 2'd1;

	always_comb begin
		blk_sum = hog_fixed_pkg::energy_t'(1);	// keeps the root finite
		for (int m = 0; m < 4; m++) begin
			blk_sum = blk_sum + win_q[hog_cell_pkg::BLOCK_MEMBERS[blk_idx][m]];
		end
	end

	assign blk_valid = (state_q != S_IDLE);
	assign blk_energy = blk_sum;

	// a window arriving mid sequence would be dropped
	a_window_idle: assert property (@(posedge aclk) disable iff (!rst_n)
		window_valid |-> !blk_valid);

endmodule

/* logic/hog_cell_pkg.sv */
// cell and block geometry
package hog_cell_pkg;

	localparam int WIN_CELLS = 9;		// 3x3 energy window
	localparam int BLOCKS = 4;		// 2x2 blocks around the cell
	localparam int BINS_PER_CELL = 18;
	localparam int BIN_PAIRS = 9;		// sign-folded bin pairs
	localparam int CELL_CREDITS = 2;	// one per root slot

	// window index of each block member, row major from 0
	// blocks are cells 1,2,4,5 / 4,5,7,8 / 2,3,5,6 / 5,6,8,9 counted from 1
	localparam int BLOCK_MEMBERS [BLOCKS][4] = '{
		'{0, 1, 3, 4},
		'{3, 4, 6, 7},
		'{1, 2, 4, 5},
		'{4, 5, 7, 8}
	};

	typedef logic [4:0] bin_cnt_t;
	typedef logic slot_t;

endpackage

/* logic/hog_fixed_pkg.sv */
// fixed point formats and constants
package hog_fixed_pkg;

	// ----------------------------------------------------------------------
	// number formats
	// ----------------------------------------------------------------------
	localparam int QN = 8;		// fraction bits
	localparam int SUM_W = 35;	// energy and root width

	typedef logic [SUM_W-1:0] energy_t;	// unsigned energy or root word
	typedef logic [QN-1:0] feat_t;		// output feature

	// ----------------------------------------------------------------------
	// arithmetic constants
	// ----------------------------------------------------------------------
	localparam energy_t TRUNC_LIMIT = 35'd51;	// 0.2 in QN
	localparam energy_t GAMMA = 35'd60;		// 1/sqrt(18) in QN

	// fast inverse square root seed
	localparam logic [31:0] MAGIC = 32'h5f37_59df;

	localparam int ISQRT_LAT = 6;	// energy to root, cycles

endpackage

/* logic/hog_norm_pca.sv */
// normalization and PCA top
`timescale 1ns/1ps

module hog_norm_pca (
	input logic aclk,
	input logic rst_n,
	input logic window_valid,
	input hog_fixed_pkg::energy_t window_energy [hog_cell_pkg::WIN_CELLS],
	input logic bin_valid,
	input hog_fixed_pkg::energy_t bin_data,
	output logic credit_return,
	output logic cell_ready,
	output logic sens_valid,
	output hog_fixed_pkg::feat_t sens_feat,
	output logic insens_valid,
	output hog_fixed_pkg::feat_t insens_feat,
	output logic tex_valid,
	output hog_fixed_pkg::feat_t tex_feat
);

	logic blk_valid, root_valid, trunc_valid;
	hog_fixed_pkg::energy_t blk_energy, root;
	hog_fixed_pkg::energy_t root0, root1, root2, root3;
	hog_fixed_pkg::energy_t trunc0, trunc1, trunc2, trunc3;

	block_energy_sum u_blk (
		.aclk(aclk), .rst_n(rst_n), .window_valid(window_valid),
		.window_energy(window_energy), .blk_valid(blk_valid), .blk_energy(blk_energy)
	);

	inv_sqrt_approx u_isqrt (
		.aclk(aclk), .rst_n(rst_n), .blk_valid(blk_valid), .blk_energy(blk_energy),
		.root_valid(root_valid), .root(root)
	);

	norm_bank u_bank (
		.aclk(aclk), .rst_n(rst_n), .root_valid(root_valid), .root(root),
		.bin_valid(bin_valid), .cell_ready(cell_ready), .credit_return(credit_return),
		.root0(root0), .root1(root1), .root2(root2), .root3(root3)
	);

	orientation_pca u_pca (
		.aclk(aclk), .rst_n(rst_n), .bin_valid(bin_valid), .bin_data(bin_data),
		.root0(root0), .root1(root1), .root2(root2), .root3(root3),
		.sens_valid(sens_valid), .sens_feat(sens_feat),
		.insens_valid(insens_valid), .insens_feat(insens_feat),
		.trunc_valid(trunc_valid), .trunc0(trunc0), .trunc1(trunc1),
		.trunc2(trunc2), .trunc3(trunc3)
	);

	texture_accumulator u_tex (
		.aclk(aclk), .rst_n(rst_n), .trunc_valid(trunc_valid),
		.trunc0(trunc0), .trunc1(trunc1), .trunc2(trunc2), .trunc3(trunc3),
		.tex_valid(tex_valid), .tex_feat(tex_feat)
	);

endmodule

/* logic/inv_sqrt_approx.sv */
// approximate inverse square root pipeline
`timescale 1ns/1ps

module inv_sqrt_approx (
	input logic aclk,
	input logic rst_n,
	input logic blk_valid,
	input hog_fixed_pkg::energy_t blk_energy,
	output logic root_valid,
	output hog_fixed_pkg::energy_t root
);

	logic [hog_fixed_pkg::ISQRT_LAT-1:0] vld_q;
	logic [5:0] lead;
	logic [hog_fixed_pkg::SUM_W+22:0] frac_ext;
	logic [31:0] f_in;
	logic [7:0] y_exp;
	logic [23:0] y_man;
	logic signed [9:0] y_sh;
	hog_fixed_pkg::energy_t y_fix;
	logic [2*hog_fixed_pkg::SUM_W-1:0] sq_full, yyr_full, rt_full;

	logic [31:0] f1_q, y2_q;
	hog_fixed_pkg::energy_t e1_q, e2_q, e3_q, e4_q;
	hog_fixed_pkg::energy_t y3_q, y4_q, y5_q;
	hog_fixed_pkg::energy_t yy4_q, t5_q, root_q;

	// ----------------------------------------------------------------------
	// stage 1, integer to float
	// ----------------------------------------------------------------------
	always_comb begin
		lead = '0;
		for (int i = 0; i < hog_fixed_pkg::SUM_W; i++) begin
			if (blk_energy[i]) lead = 6'(i);
		end
		frac_ext = {blk_energy, 23'd0} >> lead;	// bits under the leading one
		f_in = {1'b0, 8'(8'd127 + lead), frac_ext[22:0]};
	end

	// ----------------------------------------------------------------------
	// stage 3, float to QN fixed
	// ----------------------------------------------------------------------
	always_comb begin
		y_exp = y2_q[30:23];
		y_man = {1'b1, y2_q[22:0]};
		y_sh = 10'sd150 - 10'(hog_fixed_pkg::QN) - $signed({2'b00, y_exp});
		if (y_sh >= 10'sd32) begin
			y_fix = '0;	// underflow
		end else if (y_sh >= 10'sd0) begin
			y_fix = hog_fixed_pkg::energy_t'(y_man >> y_sh[4:0]);
		end else begin
			y_fix = hog_fixed_pkg::energy_t'(y_man) << (-y_sh);
		end
	end

	// newton step products, full width
	assign sq_full = {{hog_fixed_pkg::SUM_W{1'b0}}, y3_q} * {{hog_fixed_pkg::SUM_W{1'b0}}, y3_q};
	assign yyr_full = {{hog_fixed_pkg::SUM_W{1'b0}}, yy4_q} * {{hog_fixed_pkg::SUM_W{1'b0}}, e4_q};
	assign rt_full = {{hog_fixed_pkg::SUM_W{1'b0}}, y5_q} * {{hog_fixed_pkg::SUM_W{1'b0}}, t5_q};

	always_ff @(posedge aclk) begin
		f1_q <= f_in;
		e1_q <= blk_energy;
		y2_q <= hog_fixed_pkg::MAGIC - (f1_q >> 1);	// initial guess
		e2_q <= e1_q;
		y3_q <= y_fix;
		e3_q <= e2_q;
		yy4_q <= hog_fixed_pkg::energy_t'(sq_full >> hog_fixed_pkg::QN);
		y4_q <= y3_q;
		e4_q <= e3_q;
		// 3 - y*y*x in QN
		t5_q <= (hog_fixed_pkg::energy_t'(3) << hog_fixed_pkg::QN)
			- hog_fixed_pkg::energy_t'(yyr_full >> hog_fixed_pkg::QN);
		y5_q <= y4_q;
		root_q <= hog_fixed_pkg::energy_t'(rt_full >> (hog_fixed_pkg::QN + 1));
	end

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[hog_fixed_pkg::ISQRT_LAT-2:0], blk_valid};
		end
	end

	assign root_valid = vld_q[hog_fixed_pkg::ISQRT_LAT-1];
	assign root = root_q;

endmodule

/* logic/norm_bank.sv */
// two-slot root store with credit return
`timescale 1ns/1ps

module norm_bank (
	input logic aclk,
	input logic rst_n,
	input logic root_valid,
	input hog_fixed_pkg::energy_t root,
	input logic bin_valid,
	output logic cell_ready,
	output logic credit_return,
	output hog_fixed_pkg::energy_t root0,
	output hog_fixed_pkg::energy_t root1,
	output hog_fixed_pkg::energy_t root2,
	output hog_fixed_pkg::energy_t root3
);

	hog_fixed_pkg::energy_t roots_q [hog_cell_pkg::CELL_CREDITS][hog_cell_pkg::BLOCKS];
	hog_cell_pkg::slot_t wr_slot_q, rd_slot_q;
	logic [1:0] root_cnt_q;
	hog_cell_pkg::bin_cnt_t bin_cnt_q;
	logic [hog_cell_pkg::CELL_CREDITS-1:0] full_q;
	logic credit_q;
	logic last_root, last_bin;

	assign last_root = root_valid && (root_cnt_q == 2'(hog_cell_pkg::BLOCKS - 1));
	assign last_bin = bin_valid
		&& (bin_cnt_q == hog_cell_pkg::bin_cnt_t'(hog_cell_pkg::BINS_PER_CELL - 1));

	always_ff @(posedge aclk) begin
		if (root_valid) begin
			roots_q[wr_slot_q][root_cnt_q] <= root;
		end
	end

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			wr_slot_q <= 1'b0;
			rd_slot_q <= 1'b0;
			root_cnt_q <= '0;
			bin_cnt_q <= '0;
			full_q <= '0;
			credit_q <= 1'b0;
		end else begin
			credit_q <= last_bin;	// front cell consumed
			if (root_valid) root_cnt_q <= root_cnt_q + 2'd1;
			if (last_root) begin
				full_q[wr_slot_q] <= 1'b1;
				wr_slot_q <= ~wr_slot_q;
			end
			if (bin_valid) begin
				bin_cnt_q <= last_bin ? '0 : bin_cnt_q + 5'd1;
			end
			if (last_bin) begin
				full_q[rd_slot_q] <= 1'b0;
				rd_slot_q <= ~rd_slot_q;
			end
		end
	end

	// one idle cycle between cells
	assign cell_ready = full_q[rd_slot_q] & ~credit_q;
	assign credit_return = credit_q;
	assign root0 = roots_q[rd_slot_q][0];
	assign root1 = roots_q[rd_slot_q][1];
	assign root2 = roots_q[rd_slot_q][2];
	assign root3 = roots_q[rd_slot_q][3];

	// upstream credit accounting keeps a free slot for every root set
	a_no_overrun: assert property (@(posedge aclk) disable iff (!rst_n)
		root_valid |-> !full_q[wr_slot_q]);
	a_bin_ready: assert property (@(posedge aclk) disable iff (!rst_n)
		bin_valid |-> cell_ready);

endmodule

/* logic/orientation_pca.sv */
// contrast sensitive and insensitive paths
`timescale 1ns/1ps

module orientation_pca (
	input logic aclk,
	input logic rst_n,
	input logic bin_valid,
	input hog_fixed_pkg::energy_t bin_data,
	input hog_fixed_pkg::energy_t root0,
	input hog_fixed_pkg::energy_t root1,
	input hog_fixed_pkg::energy_t root2,
	input hog_fixed_pkg::energy_t root3,
	output logic sens_valid,
	output hog_fixed_pkg::feat_t sens_feat,
	output logic insens_valid,
	output hog_fixed_pkg::feat_t insens_feat,
	output logic trunc_valid,
	output hog_fixed_pkg::energy_t trunc0,
	output hog_fixed_pkg::energy_t trunc1,
	output hog_fixed_pkg::energy_t trunc2,
	output hog_fixed_pkg::energy_t trunc3
);

	logic pair_q;		// high on the second bin of a pair
	logic trunc_vld_q;
	hog_fixed_pkg::energy_t prev_q, pair_sum;

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			pair_q <= 1'b0;
			trunc_vld_q <= 1'b0;
		end else begin
			if (bin_valid) pair_q <= ~pair_q;
			trunc_vld_q <= bin_valid;	// lines up with stage 1 of u_sens
		end
	end

	always_ff @(posedge aclk) begin
		if (bin_valid) prev_q <= bin_data;
	end

	assign pair_sum = bin_data + prev_q;	// bin k plus bin k+9
	assign trunc_valid = trunc_vld_q;

	truncate_sum u_sens (
		.aclk(aclk), .rst_n(rst_n), .in_valid(bin_valid), .value(bin_data),
		.root0(root0), .root1(root1), .root2(root2), .root3(root3),
		.out_valid(sens_valid), .trunc0(trunc0), .trunc1(trunc1),
		.trunc2(trunc2), .trunc3(trunc3), .feat(sens_feat)
	);

	truncate_sum u_insens (
		.aclk(aclk), .rst_n(rst_n), .in_valid(bin_valid & pair_q), .value(pair_sum),
		.root0(root0), .root1(root1), .root2(root2), .root3(root3),
		.out_valid(insens_valid), .trunc0(), .trunc1(),
		.trunc2(), .trunc3(), .feat(insens_feat)
	);

endmodule

/* logic/texture_accumulator.sv */
// texture features per block
`timescale 1ns/1ps

module texture_accumulator (
	input logic aclk,
	input logic rst_n,
	input logic trunc_valid,
	input hog_fixed_pkg::energy_t trunc0,
	input hog_fixed_pkg::energy_t trunc1,
	input hog_fixed_pkg::energy_t trunc2,
	input hog_fixed_pkg::energy_t trunc3,
	output logic tex_valid,
	output hog_fixed_pkg::feat_t tex_feat
);

	hog_fixed_pkg::energy_t trunc_in [hog_cell_pkg::BLOCKS];
	hog_fixed_pkg::energy_t acc_q [hog_cell_pkg::BLOCKS];
	logic [2*hog_fixed_pkg::SUM_W-1:0] scale_full [hog_cell_pkg::BLOCKS];
	hog_fixed_pkg::feat_t scaled_q [hog_cell_pkg::BLOCKS];
	hog_cell_pkg::bin_cnt_t set_cnt_q;
	logic last_set, tot_valid_q, tex_valid_q;
	logic [1:0] sel_q;

	assign trunc_in = '{trunc0, trunc1, trunc2, trunc3};
	assign last_set = trunc_valid
		&& (set_cnt_q == hog_cell_pkg::bin_cnt_t'(hog_cell_pkg::BINS_PER_CELL - 1));

	always_comb begin
		for (int k = 0; k < hog_cell_pkg::BLOCKS; k++) begin
			scale_full[k] = {{hog_fixed_pkg::SUM_W{1'b0}}, acc_q[k]}
				* {{hog_fixed_pkg::SUM_W{1'b0}}, hog_fixed_pkg::GAMMA};
		end
	end

	// ----------------------------------------------------------------------
	// block totals and gamma scaling
	// ----------------------------------------------------------------------
	always_ff @(posedge aclk) begin
		for (int k = 0; k < hog_cell_pkg::BLOCKS; k++) begin
			if (trunc_valid) begin
				acc_q[k] <= (set_cnt_q == '0) ? trunc_in[k] : acc_q[k] + trunc_in[k];
			end
			if (tot_valid_q) begin
				scaled_q[k] <= hog_fixed_pkg::feat_t'(scale_full[k] >> hog_fixed_pkg::QN);
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			set_cnt_q <= '0;
			tot_valid_q <= 1'b0;
			tex_valid_q <= 1'b0;
			sel_q <= '0;
		end else begin
			tot_valid_q <= last_set;
			if (trunc_valid) set_cnt_q <= last_set ? '0 : set_cnt_q + 5'd1;
			if (tot_valid_q) begin
				tex_valid_q <= 1'b1;	// serializer start
				sel_q <= '0;
			end else if (tex_valid_q) begin
				if (sel_q == 2'd3) tex_valid_q <= 1'b0;
				sel_q <= sel_q + 2'd1;
			end
		end
	end

	assign tex_valid = tex_valid_q;
	assign tex_feat = scaled_q[sel_q];	// block 0 first

endmodule

/* logic/truncate_sum.sv */
// normalize, clamp and sum
`timescale 1ns/1ps

module truncate_sum (
	input logic aclk,
	input logic rst_n,
	input logic in_valid,
	input hog_fixed_pkg::energy_t value,
	input hog_fixed_pkg::energy_t root0,
	input hog_fixed_pkg::energy_t root1,
	input hog_fixed_pkg::energy_t root2,
	input hog_fixed_pkg::energy_t root3,
	output logic out_valid,
	output hog_fixed_pkg::energy_t trunc0,
	output hog_fixed_pkg::energy_t trunc1,
	output hog_fixed_pkg::energy_t trunc2,
	output hog_fixed_pkg::energy_t trunc3,
	output hog_fixed_pkg::feat_t feat
);

	hog_fixed_pkg::energy_t roots [hog_cell_pkg::BLOCKS];
	hog_fixed_pkg::energy_t norm, clamp [hog_cell_pkg::BLOCKS];
	hog_fixed_pkg::energy_t trunc_q [hog_cell_pkg::BLOCKS];
	hog_fixed_pkg::energy_t tsum;
	logic [2*hog_fixed_pkg::SUM_W-1:0] prod;
	logic v1_q, v2_q;
	hog_fixed_pkg::feat_t feat_q;

	assign roots = '{root0, root1, root2, root3};

	always_comb begin
		for (int k = 0; k < hog_cell_pkg::BLOCKS; k++) begin
			prod = {{hog_fixed_pkg::SUM_W{1'b0}}, value} * {{hog_fixed_pkg::SUM_W{1'b0}}, roots[k]};
			norm = hog_fixed_pkg::energy_t'(prod >> hog_fixed_pkg::QN);
			clamp[k] = (norm < hog_fixed_pkg::TRUNC_LIMIT) ? norm : hog_fixed_pkg::TRUNC_LIMIT;
		end
	end

	assign tsum = trunc_q[0] + trunc_q[1] + trunc_q[2] + trunc_q[3];

	always_ff @(posedge aclk) begin
		trunc_q <= clamp;
		feat_q <= hog_fixed_pkg::feat_t'(tsum >> 1);	// sum halved
	end

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			v1_q <= 1'b0;
			v2_q <= 1'b0;
		end else begin
			v1_q <= in_valid;
			v2_q <= v1_q;
		end
	end

	assign out_valid = v2_q;
	assign trunc0 = trunc_q[0];
	assign trunc1 = trunc_q[1];
	assign trunc2 = trunc_q[2];
	assign trunc3 = trunc_q[3];
	assign feat = feat_q;

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module hog_norm_tb -f hog_norm.f -o sim_hog_norm

# the simulator exits non-zero on $fatal, the log decides
./obj_dir/sim_hog_norm > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
echo "simulation passed"

/* verification/hog_norm_model.svh */
// reference model for roots and features
`ifndef HOG_NORM_MODEL_SVH
`define HOG_NORM_MODEL_SVH

// block b spans rows b%2..b%2+1 and columns b/2..b/2+1 of the window
function automatic hog_fixed_pkg::energy_t ref_block_energy(
	input hog_fixed_pkg::energy_t win [hog_cell_pkg::WIN_CELLS],
	input int b);
	hog_fixed_pkg::energy_t s;
	s = hog_fixed_pkg::energy_t'(1);
	for (int i = 0; i < 2; i++) begin
		for (int j = 0; j < 2; j++) begin
			s = s + win[(b % 2 + i) * 3 + b / 2 + j];
		end
	end
	return s;
endfunction

// float seed, magic subtract, back to QN, one newton step
function automatic hog_fixed_pkg::energy_t ref_inv_sqrt(input hog_fixed_pkg::energy_t e);
	int lead;
	int sh;
	logic [57:0] frac_ext;
	logic [31:0] f;
	logic [31:0] y2;
	logic [23:0] man;
	logic [69:0] p;
	hog_fixed_pkg::energy_t y;
	hog_fixed_pkg::energy_t yy;
	hog_fixed_pkg::energy_t t;
	lead = 0;
	for (int i = 0; i < hog_fixed_pkg::SUM_W; i++) begin
		if (e[i]) lead = i;
	end
	frac_ext = {e, 23'd0} >> lead;
	f = {1'b0, 8'(127 + lead), frac_ext[22:0]};
	y2 = hog_fixed_pkg::MAGIC - (f >> 1);
	man = {1'b1, y2[22:0]};
	sh = 150 - hog_fixed_pkg::QN - int'(y2[30:23]);
	if (sh >= 32) y = '0;
	else if (sh >= 0) y = hog_fixed_pkg::energy_t'(man >> sh);
	else y = hog_fixed_pkg::energy_t'(man) << (-sh);
	p = 70'(y) * 70'(y);
	yy = hog_fixed_pkg::energy_t'(p >> hog_fixed_pkg::QN);
	p = 70'(yy) * 70'(e);
	t = (hog_fixed_pkg::energy_t'(3) << hog_fixed_pkg::QN)
		- hog_fixed_pkg::energy_t'(p >> hog_fixed_pkg::QN);
	p = 70'(y) * 70'(t);
	return hog_fixed_pkg::energy_t'(p >> (hog_fixed_pkg::QN + 1));
endfunction

// one normalized value, clamped
function automatic hog_fixed_pkg::energy_t ref_clamp(input hog_fixed_pkg::energy_t value,
	input hog_fixed_pkg::energy_t r);
	logic [69:0] p;
	hog_fixed_pkg::energy_t n;
	p = 70'(value) * 70'(r);
	n = hog_fixed_pkg::energy_t'(p >> hog_fixed_pkg::QN);
	return (n < hog_fixed_pkg::TRUNC_LIMIT) ? n : hog_fixed_pkg::TRUNC_LIMIT;
endfunction

function automatic hog_fixed_pkg::feat_t ref_sens(input hog_fixed_pkg::energy_t value,
	input hog_fixed_pkg::energy_t r0, input hog_fixed_pkg::energy_t r1,
	input hog_fixed_pkg::energy_t r2, input hog_fixed_pkg::energy_t r3);
	hog_fixed_pkg::energy_t s;
	s = ref_clamp(value, r0) + ref_clamp(value, r1) + ref_clamp(value, r2)
		+ ref_clamp(value, r3);
	return hog_fixed_pkg::feat_t'(s >> 1);
endfunction

function automatic hog_fixed_pkg::feat_t ref_insens(input hog_fixed_pkg::energy_t first,
	input hog_fixed_pkg::energy_t second,
	input hog_fixed_pkg::energy_t r0, input hog_fixed_pkg::energy_t r1,
	input hog_fixed_pkg::energy_t r2, input hog_fixed_pkg::energy_t r3);
	hog_fixed_pkg::energy_t pair;
	pair = first + second;	// bin k plus bin k+9
	return ref_sens(pair, r0, r1, r2, r3);
endfunction

// block total of truncated values, gamma scaled
function automatic hog_fixed_pkg::feat_t ref_tex(input hog_fixed_pkg::energy_t total);
	logic [69:0] p;
	p = 70'(total) * 70'(hog_fixed_pkg::GAMMA);
	return hog_fixed_pkg::feat_t'(p >> hog_fixed_pkg::QN);
endfunction

`endif

/* verification/hog_norm_tb.sv */
// normalization and PCA testbench
`timescale 1ns/1ps

module hog_norm_tb;

	localparam int NUM_CELLS = 12;
	localparam int BINS = hog_cell_pkg::BINS_PER_CELL;
	localparam int DRIVE_DELAY = 2;
	localparam int WIN_GAP = 5;		// block sequencer busy time
	localparam int HOLD_CYCLES = 40;
	localparam int IDLE_CYCLES = 6;
	localparam int TIMEOUT_CYCLES = 200 * NUM_CELLS + 200;

	logic aclk;
	logic rst_n;
	logic window_valid;
	hog_fixed_pkg::energy_t window_energy [hog_cell_pkg::WIN_CELLS];
	logic bin_valid;
	hog_fixed_pkg::energy_t bin_data;
	logic credit_return;
	logic cell_ready;
	logic sens_valid;
	hog_fixed_pkg::feat_t sens_feat;
	logic insens_valid;
	hog_fixed_pkg::feat_t insens_feat;
	logic tex_valid;
	hog_fixed_pkg::feat_t tex_feat;

	integer seed = 20;
	int cycle_cnt = 0;
	int sent_cnt = 0;	// windows sent
	int returned_cnt = 0;	// credit pulses seen
	int cells_done = 0;	// cells whose bins are all sent
	int sens_seen = 0;
	int tex_seen = 0;
	bit credit_prev = 1'b0;

	hog_fixed_pkg::energy_t cur_win [hog_cell_pkg::WIN_CELLS];
	hog_fixed_pkg::energy_t win_mem [NUM_CELLS][hog_cell_pkg::WIN_CELLS];
	hog_fixed_pkg::energy_t bin_mem [NUM_CELLS][BINS];	// in stream order 0,9,1,10..
	bit gap_mem [NUM_CELLS][BINS];
	hog_fixed_pkg::feat_t sens_q [$];
	hog_fixed_pkg::feat_t insens_q [$];
	hog_fixed_pkg::feat_t tex_q [$];

	`include "hog_norm_model.svh"

	hog_norm_pca dut0 (
		.aclk(aclk), .rst_n(rst_n), .window_valid(window_valid),
		.window_energy(window_energy), .bin_valid(bin_valid), .bin_data(bin_data),
		.credit_return(credit_return), .cell_ready(cell_ready),
		.sens_valid(sens_valid), .sens_feat(sens_feat),
		.insens_valid(insens_valid), .insens_feat(insens_feat),
		.tex_valid(tex_valid), .tex_feat(tex_feat)
	);

	initial begin
		aclk = 1'b0;
		forever #10 aclk = ~aclk;
	end

	// ----------------------------------------------------------------------
	// error handling and compare tasks
	// ----------------------------------------------------------------------
	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_sens(input hog_fixed_pkg::feat_t got, input hog_fixed_pkg::feat_t exp);
		if (got !== exp)
			stop_with_error($sformatf("ERROR at %0t: sens_feat %0d, expected %0d", $time, got, exp));
	endtask

	task automatic check_insens(input hog_fixed_pkg::feat_t got,
		input hog_fixed_pkg::feat_t exp);
		if (got !== exp)
			stop_with_error($sformatf("ERROR at %0t: insens_feat %0d, expected %0d",
				$time, got, exp));
	endtask

	task automatic check_tex(input hog_fixed_pkg::feat_t got, input hog_fixed_pkg::feat_t exp);
		if (got !== exp)
			stop_with_error($sformatf("ERROR at %0t: tex_feat %0d, expected %0d", $time, got, exp));
	endtask

	// ----------------------------------------------------------------------
	// stimulus and expected values
	// ----------------------------------------------------------------------
	task automatic build_stimulus();
		int shift;
		hog_fixed_pkg::energy_t rt [hog_cell_pkg::BLOCKS];
		hog_fixed_pkg::energy_t tot [hog_cell_pkg::BLOCKS];
		for (int c = 0; c < NUM_CELLS; c++) begin
			shift = (c == 0) ? 18 : $unsigned($random(seed)) % 20;	// cell 0 tiny energies
			for (int k = 0; k < hog_cell_pkg::WIN_CELLS; k++) begin
				cur_win[k] = hog_fixed_pkg::energy_t'($unsigned($random(seed)) & 32'h000F_FFFF)
					>> shift;
				win_mem[c][k] = cur_win[k];
			end
			for (int b = 0; b < hog_cell_pkg::BLOCKS; b++) begin
				rt[b] = ref_inv_sqrt(ref_block_energy(cur_win, b));
				tot[b] = '0;
			end
			shift = (c == 0) ? 0 : 4 + $unsigned($random(seed)) % 16;
			for (int p = 0; p < BINS; p++) begin
				bin_mem[c][p] = hog_fixed_pkg::energy_t'($unsigned($random(seed)) & 32'h000F_FFFF)
					>> shift;
				if (c == 0) bin_mem[c][p] = bin_mem[c][p] | (hog_fixed_pkg::energy_t'(1) << 19);
				gap_mem[c][p] = ($unsigned($random(seed)) % 4) == 0;
				sens_q.push_back(ref_sens(bin_mem[c][p], rt[0], rt[1], rt[2], rt[3]));
				if (p % 2 == 1)
					insens_q.push_back(ref_insens(bin_mem[c][p-1], bin_mem[c][p],
						rt[0], rt[1], rt[2], rt[3]));
				for (int b = 0; b < hog_cell_pkg::BLOCKS; b++) begin
					tot[b] = tot[b] + ref_clamp(bin_mem[c][p], rt[b]);
				end
			end
			for (int b = 0; b < hog_cell_pkg::BLOCKS; b++) begin
				tex_q.push_back(ref_tex(tot[b]));
			end
		end
	endtask

	// one window per credit, spaced by the sequencer busy time
	task automatic drive_windows();
		int last_cyc;
		last_cyc = -WIN_GAP;
		repeat (IDLE_CYCLES) @(posedge aclk);
		for (int c = 0; c < NUM_CELLS; c++) begin
			@(posedge aclk);
			#DRIVE_DELAY;
			window_valid = 1'b0;
			while (sent_cnt - returned_cnt >= hog_cell_pkg::CELL_CREDITS
				|| cycle_cnt - last_cyc < WIN_GAP) begin
				@(posedge aclk);
				#DRIVE_DELAY;
			end
			for (int k = 0; k < hog_cell_pkg::WIN_CELLS; k++) begin
				window_energy[k] = win_mem[c][k];
			end
			window_valid = 1'b1;
			sent_cnt++;
			last_cyc = cycle_cnt;
		end
		@(posedge aclk);
		#DRIVE_DELAY;
		window_valid = 1'b0;
	endtask

	task automatic drive_bins();
		int i;
		bit gap_used;
		gap_used = 1'b0;
		for (int c = 0; c < NUM_CELLS; c++) begin
			if (c == 1) begin
				// second cell held back, its slot must stay put
				repeat (HOLD_CYCLES) @(posedge aclk);
				#DRIVE_DELAY;
				if (returned_cnt != 1 || !cell_ready)
					stop_with_error("credit or cell_ready changed while bins were held back");
			end
			i = 0;
			while (i < BINS) begin
				@(posedge aclk);
				#DRIVE_DELAY;
				bin_valid = 1'b0;
				if (cell_ready && gap_mem[c][i] && !gap_used) begin
					gap_used = 1'b1;	// one idle cycle
				end else if (cell_ready) begin
					bin_data = bin_mem[c][i];
					bin_valid = 1'b1;
					gap_used = 1'b0;
					i++;
				end
			end
			@(posedge aclk);
			#DRIVE_DELAY;
			bin_valid = 1'b0;
			cells_done++;
		end
	endtask

	// ----------------------------------------------------------------------
	// output checks, sampled mid cycle
	// ----------------------------------------------------------------------
	initial begin
		hog_fixed_pkg::feat_t clamp_feat;
		clamp_feat = hog_fixed_pkg::feat_t'((hog_fixed_pkg::energy_t'(4)
			* hog_fixed_pkg::TRUNC_LIMIT) >> 1);
		forever begin
			@(negedge aclk);
			if (rst_n === 1'b1) begin
				if (sent_cnt == 0 && (sens_valid !== 1'b0 || insens_valid !== 1'b0
					|| tex_valid !== 1'b0 || cell_ready !== 1'b0 || credit_return !== 1'b0))
					stop_with_error("an output went active before any window was sent");
				if (sent_cnt - returned_cnt > hog_cell_pkg::CELL_CREDITS)
					stop_with_error("more windows outstanding than credits");
				if (sens_valid) begin
					if (sens_q.size() == 0) begin
						stop_with_error("sens_valid with no expected feature left");
					end else begin
						check_sens(sens_feat, sens_q.pop_front());
						if (sens_seen < BINS) check_sens(sens_feat, clamp_feat);	// clamp cell
						sens_seen++;
					end
				end
				if (insens_valid) begin
					if (insens_q.size() == 0) stop_with_error("insens_valid with no expected feature left");
					else check_insens(insens_feat, insens_q.pop_front());
				end
				if (tex_valid) begin
					if (tex_q.size() == 0) begin
						stop_with_error("tex_valid with no expected feature left");
					end else begin
						check_tex(tex_feat, tex_q.pop_front());
						tex_seen++;
					end
				end
				if (credit_return) begin
					if (credit_prev) stop_with_error("credit_return stayed high for two cycles");
					else if (returned_cnt >= cells_done)
						stop_with_error("credit_return pulsed without a finished cell");
					else returned_cnt++;
				end
				credit_prev = credit_return;
			end
		end
	end

	initial begin
		forever begin
			@(posedge aclk);
			cycle_cnt++;
			if (cycle_cnt > TIMEOUT_CYCLES)
				stop_with_error("timeout, the run did not complete within the cycle limit");
		end
	end

	initial begin
		rst_n = 1'b0;
		window_valid = 1'b0;
		bin_valid = 1'b0;
		bin_data = '0;
		for (int k = 0; k < hog_cell_pkg::WIN_CELLS; k++) begin
			window_energy[k] = '0;
		end
		build_stimulus();
		repeat (2) @(posedge aclk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		fork
			drive_windows();
			drive_bins();
		join
		while (sens_q.size() != 0 || insens_q.size() != 0 || tex_q.size() != 0) begin
			@(posedge aclk);
		end
		repeat (20) @(posedge aclk);	// catch stray outputs
		if (returned_cnt == NUM_CELLS && tex_seen == 4 * NUM_CELLS
			&& sens_seen == NUM_CELLS * BINS) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			stop_with_error($sformatf("wrong totals at the end: %0d credits, %0d texture features",
				returned_cnt, tex_seen));
		end
	end

endmodule
